//--- a2_host_pkg.sv
//==================================================
// Shared types for the Apple II host glue
// Option word layout, display and effect enums,
// video config, game port and memory request structs
//==================================================

package a2_host_pkg;

	// ==================================================
	// Fixed widths
	// ==================================================

	// Core memory address, covers main and aux space
	localparam int RAM_ADDR_W = 18;
	// Aux bank is 64K, indexed by the low address bits
	localparam int AUX_ADDR_W = 16;

	// ==================================================
	// Host option word
	// ==================================================

	// Declared from the top bit down
	// Bit 0 (cold reset) sits inside reserved_0
	typedef struct packed {
		logic [9:0] reserved_hi;
		logic [2:0] display;
		logic       paddle_y;
		logic       paddle_x;
		logic       pixel_normal;
		logic [1:0] scale;
		logic [1:0] aspect;
		logic [2:0] fx;
		logic [1:0] stereo_mix;
		logic       analog_swap;
		logic       cpu_65c02;
		logic       mb_disable;
		logic [3:0] reserved_0;
	} a2_status_t;

	// Display menu codes, offset by one from the menu index
	// Code zero is plain colour with no text colour
	typedef enum logic [2:0] {
		DISP_COLOR1 = 3'd1,
		DISP_COLOR2 = 3'd2,
		DISP_BW     = 3'd3,
		DISP_GREEN  = 3'd4,
		DISP_AMBER  = 3'd5
	} display_e;

	// Scandoubler effect menu
	typedef enum logic [2:0] {
		FX_NONE  = 3'd0,
		FX_HQ2X  = 3'd1,
		FX_CRT25 = 3'd2,
		FX_CRT50 = 3'd3,
		FX_CRT75 = 3'd4
	} fx_e;

	// ==================================================
	// Decoded settings and core-side bundles
	// ==================================================

	// Video settings handed to the scaler side
	typedef struct packed {
		logic [1:0]  screen_mode;
		logic        text_color;
		logic [1:0]  scanlines;
		logic        hq2x;
		logic        scandoubler;
		logic [11:0] arx;
		logic [11:0] ary;
	} video_cfg_t;

	// Game port as seen by the core
	typedef struct packed {
		logic [5:0]  joy_dig;
		logic [15:0] joy_an;
	} game_port_t;

	// Byte-wide memory request from the core
	typedef struct packed {
		logic [RAM_ADDR_W-1:0] addr;
		logic [7:0]            din;
		logic                  we;
		logic                  aux;
	} ram_req_t;

	// Hard-disk sequencer states
	typedef enum logic {
		HDD_IDLE = 1'b0,
		HDD_XFER = 1'b1
	} hdd_state_e;

endpackage

//--- option_decode.sv
//==================================================
// Option word decode to video settings
// Pixel clock enable divider, two rates
//==================================================

`timescale 1ns/10ps

module option_decode (
	input  logic                    clk_sys,
	input  logic                    dd_reset,
	input  a2_host_pkg::a2_status_t status,
	input  logic                    forced_scandoubler,
	output a2_host_pkg::video_cfg_t video_cfg,
	output logic                    ce_pix
);

	a2_host_pkg::display_e disp_code;
	a2_host_pkg::fx_e      fx_code;
	// Effect code minus one gives the scanline depth
	logic [2:0]            fx_minus_one;
	// Free-running pixel divider
	logic [2:0]            pix_div;

	assign disp_code    = a2_host_pkg::display_e'(status.display);
	assign fx_code      = a2_host_pkg::fx_e'(status.fx);
	assign fx_minus_one = status.fx - 3'd1;

	// ==================================================
	// Settings decode
	// ==================================================
	always_comb begin
		// Plain colour unless a mono display is picked
		video_cfg.screen_mode = 2'd0;
		video_cfg.text_color  = 1'b0;
		case (disp_code)
			a2_host_pkg::DISP_COLOR1: video_cfg.text_color  = 1'b1;
			a2_host_pkg::DISP_COLOR2: video_cfg.screen_mode = 2'd0;
			a2_host_pkg::DISP_BW:     video_cfg.screen_mode = 2'd1;
			a2_host_pkg::DISP_GREEN:  video_cfg.screen_mode = 2'd2;
			a2_host_pkg::DISP_AMBER:  video_cfg.screen_mode = 2'd3;
			default:                  video_cfg.screen_mode = 2'd0;
		endcase

		// Scanlines start at HQ2x with zero depth
		if (fx_code == a2_host_pkg::FX_NONE) begin
			video_cfg.scanlines = 2'd0;
		end else begin
			video_cfg.scanlines = fx_minus_one[1:0];
		end
		video_cfg.hq2x        = (fx_code == a2_host_pkg::FX_HQ2X);
		// Any effect needs the doubler, the host may also force it
		video_cfg.scandoubler = (fx_code != a2_host_pkg::FX_NONE) | forced_scandoubler;

		// Original aspect is 4:3
		// Other choices pass the preset index with a zero height
		if (status.aspect == 2'd0) begin
			video_cfg.arx = 12'd4;
			video_cfg.ary = 12'd3;
		end else begin
			video_cfg.arx = {10'd0, status.aspect - 2'd1};
			video_cfg.ary = 12'd0;
		end
	end

	// ==================================================
	// Pixel enable
	// ==================================================
	// Normal rate pulses once per 8 clocks, double rate once per 4
	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			pix_div <= 3'd0;
			ce_pix  <= 1'b0;
		end else begin
			pix_div <= pix_div + 3'd1;
			ce_pix  <= status.pixel_normal ? (&pix_div) : (&pix_div[1:0]);
		end
	end

endmodule

//--- joystick_map.sv
//==================================================
// Game port mapping
// Analog axis swap, paddle override, direction mask
//==================================================

`timescale 1ns/10ps

module joystick_map (
	input  a2_host_pkg::a2_status_t status,
	input  logic [15:0]             joystick_0,
	input  logic [15:0]             joystick_a0,
	input  logic [7:0]              paddle_0,
	output a2_host_pkg::game_port_t game_port
);

	// Paddle with the sign bit flipped to match the axis range
	logic [7:0]  paddle_adj;
	// Axes after the optional byte swap
	logic [15:0] axes;
	// Set when an axis has no analog deflection
	logic        x_idle;
	logic        y_idle;

	assign paddle_adj = {~paddle_0[7], paddle_0[6:0]};

	// Host sends Y:X, core wants X:Y by default
	assign axes = status.analog_swap ? joystick_a0
	                                 : {joystick_a0[7:0], joystick_a0[15:8]};

	// ==================================================
	// Analog axes
	// ==================================================
	// High byte is X, low byte is Y
	assign game_port.joy_an[15:8] = status.paddle_x ? paddle_adj : axes[15:8];
	assign game_port.joy_an[7:0]  = status.paddle_y ? paddle_adj : axes[7:0];

	// ==================================================
	// Digital inputs
	// ==================================================
	// Idle check uses the stick, not the paddle substitute
	assign x_idle = ~|axes[15:8];
	assign y_idle = ~|axes[7:0];

	// Bits 5:4 fire buttons, 3:2 up/down, 1:0 left/right
	// A moved analog axis silences its digital pair
	assign game_port.joy_dig = joystick_0[5:0] & {2'b11, {2{y_idle}}, {2{x_idle}}};

endmodule

//--- bank_ram.sv
//==================================================
// Main and auxiliary system memory banks
// One-cycle read, written byte shows on the next read
//==================================================

`timescale 1ns/10ps

module bank_ram #(
	parameter int MAIN_DEPTH = 196608,
	parameter int AUX_DEPTH  = 65536
) (
	input  logic                  clk_sys,
	input  a2_host_pkg::ram_req_t ram,
	output logic [15:0]           ram_dout
);

	// Storage
	logic [7:0] main_mem [MAIN_DEPTH];
	logic [7:0] aux_mem  [AUX_DEPTH];

	// Per-bank write strobes
	logic       main_we;
	logic       aux_we;
	// Aux bank sees only the low address bits
	logic [a2_host_pkg::AUX_ADDR_W-1:0] aux_addr;

	assign main_we  = ram.we & ~ram.aux;
	assign aux_we   = ram.we & ram.aux;
	assign aux_addr = ram.addr[a2_host_pkg::AUX_ADDR_W-1:0];

	// ==================================================
	// Main bank, low byte of the read data
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (main_we) begin
			main_mem[ram.addr] <= ram.din;
			// Write-through so the core sees its own byte
			ram_dout[7:0]      <= ram.din;
		end else begin
			ram_dout[7:0]      <= main_mem[ram.addr];
		end
	end

	// ==================================================
	// Aux bank, high byte of the read data
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (aux_we) begin
			aux_mem[aux_addr] <= ram.din;
			ram_dout[15:8]    <= ram.din;
		end else begin
			// Read of the same address while main is written
			ram_dout[15:8]    <= aux_mem[aux_addr];
		end
	end

endmodule

//--- hdd_request.sv
//==================================================
// Hard-disk sector request sequencer with CPU wait
// Image mount and write-protect latches
//==================================================

`timescale 1ns/10ps

module hdd_request (
	input  logic        clk_sys,
	input  logic        dd_reset,
	input  logic        hdd_read,
	input  logic        hdd_write,
	input  logic        sd_ack,
	input  logic        img_mounted,
	input  logic [63:0] img_size,
	input  logic        img_readonly,
	output logic        sd_rd,
	output logic        sd_wr,
	output logic        cpu_wait,
	output logic        hdd_mounted,
	output logic        hdd_protect
);

	a2_host_pkg::hdd_state_e state;

	// Sticky request flags, set by core pulses
	logic read_pending;
	logic write_pending;
	// Previous acknowledge for edge detection
	logic ack_d;
	logic ack_rise;
	logic ack_fall;

	assign ack_rise = ~ack_d & sd_ack;
	assign ack_fall = ack_d & ~sd_ack;

	// ==================================================
	// Request sequencer
	// ==================================================
	// Idle waits for a pending request and raises the host strobe
	// Xfer drops the strobe on ack rise, releases the CPU on ack fall
	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			state         <= a2_host_pkg::HDD_IDLE;
			read_pending  <= 1'b0;
			write_pending <= 1'b0;
			ack_d         <= 1'b0;
			sd_rd         <= 1'b0;
			sd_wr         <= 1'b0;
			cpu_wait      <= 1'b0;
		end else begin
			ack_d         <= sd_ack;
			read_pending  <= read_pending | hdd_read;
			write_pending <= write_pending | hdd_write;

			case (state)
				a2_host_pkg::HDD_IDLE: begin
					if (read_pending | write_pending) begin
						state    <= a2_host_pkg::HDD_XFER;
						sd_rd    <= read_pending;
						sd_wr    <= write_pending;
						cpu_wait <= 1'b1;
					end
				end
				a2_host_pkg::HDD_XFER: begin
					if (ack_rise) begin
						// Host took the request
						// Flags not issued with it wait for the next round
						read_pending  <= (read_pending & ~sd_rd) | hdd_read;
						write_pending <= (write_pending & ~sd_wr) | hdd_write;
						sd_rd         <= 1'b0;
						sd_wr         <= 1'b0;
					end else if (ack_fall) begin
						state    <= a2_host_pkg::HDD_IDLE;
						cpu_wait <= 1'b0;
					end
				end
				default: state <= a2_host_pkg::HDD_IDLE;
			endcase
		end
	end

	// ==================================================
	// Image status
	// ==================================================
	// Zero size means the image was ejected
	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			hdd_mounted <= 1'b0;
			hdd_protect <= 1'b0;
		end else if (img_mounted) begin
			hdd_mounted <= (img_size != 64'd0);
			hdd_protect <= img_readonly;
		end
	end

endmodule

//--- a2_host_top.sv
//==================================================
// Host glue top level for the Apple II core
// Option decode, game port, memory, hard-disk link
// Audio sample formatting
//==================================================

`timescale 1ns/10ps

module a2_host_top #(
	parameter int MAIN_DEPTH = 196608,
	parameter int AUX_DEPTH  = 65536
) (
	input  logic                    clk_sys,
	input  logic                    dd_reset,

	// Host options
	input  a2_host_pkg::a2_status_t status,
	input  logic                    forced_scandoubler,

	// Host game inputs
	input  logic [15:0]             joystick_0,
	input  logic [15:0]             joystick_a0,
	input  logic [7:0]              paddle_0,

	// Core memory port
	input  a2_host_pkg::ram_req_t   ram,
	output logic [15:0]             ram_dout,

	// Core hard-disk controls
	input  logic                    hdd_read,
	input  logic                    hdd_write,
	output logic                    hdd_mounted,
	output logic                    hdd_protect,
	output logic                    cpu_wait,

	// Host disk link
	output logic                    sd_rd,
	output logic                    sd_wr,
	input  logic                    sd_ack,
	input  logic                    img_mounted,
	input  logic [63:0]             img_size,
	input  logic                    img_readonly,

	// Audio
	input  logic [9:0]              core_audio_l,
	input  logic [9:0]              core_audio_r,
	output logic [15:0]             audio_l,
	output logic [15:0]             audio_r,
	output logic                    audio_s,
	output logic [1:0]              audio_mix,

	// Video settings and core game port
	output a2_host_pkg::video_cfg_t video_cfg,
	output logic                    ce_pix,
	output a2_host_pkg::game_port_t game_port
);

	// ==================================================
	// Submodules
	// ==================================================
	option_decode option_decode_inst (
		.clk_sys            (clk_sys),
		.dd_reset           (dd_reset),
		.status             (status),
		.forced_scandoubler (forced_scandoubler),
		.video_cfg          (video_cfg),
		.ce_pix             (ce_pix)
	);

	joystick_map joystick_map_inst (
		.status      (status),
		.joystick_0  (joystick_0),
		.joystick_a0 (joystick_a0),
		.paddle_0    (paddle_0),
		.game_port   (game_port)
	);

	bank_ram #(
		.MAIN_DEPTH (MAIN_DEPTH),
		.AUX_DEPTH  (AUX_DEPTH)
	) bank_ram_inst (
		.clk_sys  (clk_sys),
		.ram      (ram),
		.ram_dout (ram_dout)
	);

	hdd_request hdd_request_inst (
		.clk_sys      (clk_sys),
		.dd_reset     (dd_reset),
		.hdd_read     (hdd_read),
		.hdd_write    (hdd_write),
		.sd_ack       (sd_ack),
		.img_mounted  (img_mounted),
		.img_size     (img_size),
		.img_readonly (img_readonly),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.cpu_wait     (cpu_wait),
		.hdd_mounted  (hdd_mounted),
		.hdd_protect  (hdd_protect)
	);

	// ==================================================
	// Audio
	// ==================================================
	// Unsigned 10-bit sample placed below a clear top bit
	assign audio_l   = {1'b0, core_audio_l, 5'd0};
	assign audio_r   = {1'b0, core_audio_r, 5'd0};
	assign audio_s   = 1'b0;
	// Stereo blend straight from the menu
	assign audio_mix = status.stereo_mix;

endmodule

//--- tb_clock.sv
//==================================================
// Testbench clock and reset generator
//==================================================

`timescale 1ns/10ps

module tb_clock #(
	parameter real PERIOD_NS    = 4.0,
	parameter int  RESET_CYCLES = 4
) (
	output logic clk_sys,
	output logic dd_reset
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD_NS / 2.0) clk_sys = ~clk_sys;
	end

	// Reset drops on a rising edge like the rest of the stimulus
	initial begin
		dd_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		dd_reset <= 1'b0;
	end

endmodule

//--- tb_a2_host.sv
//==================================================
// Testbench for the Apple II host glue
// Option and game port table, pixel enable, memory,
// hard-disk handshake and image mount checks
//==================================================

`timescale 1ns/10ps

module tb_a2_host;

	// Well over the total length of all test phases
	localparam int TIMEOUT_CYCLES = 4000;

	typedef struct packed {
		a2_host_pkg::a2_status_t  status;
		logic [15:0]              joy_dig_in;
		logic [15:0]              joy_an_in;
		logic [7:0]               paddle;
		logic                     forced;
		a2_host_pkg::video_cfg_t  video;
		a2_host_pkg::game_port_t  port;
	} option_row_t;

	logic clk_sys;
	logic dd_reset;
	a2_host_pkg::a2_status_t status;
	logic forced_scandoubler;
	logic [15:0] joystick_0;
	logic [15:0] joystick_a0;
	logic [7:0] paddle_0;
	a2_host_pkg::ram_req_t ram;
	logic [15:0] ram_dout;
	logic hdd_read;
	logic hdd_write;
	logic hdd_mounted;
	logic hdd_protect;
	logic cpu_wait;
	logic sd_rd;
	logic sd_wr;
	logic sd_ack;
	logic img_mounted;
	logic [63:0] img_size;
	logic img_readonly;
	logic [9:0] core_audio_l;
	logic [9:0] core_audio_r;
	logic [15:0] audio_l;
	logic [15:0] audio_r;
	logic audio_s;
	logic [1:0] audio_mix;
	a2_host_pkg::video_cfg_t video_cfg;
	logic ce_pix;
	a2_host_pkg::game_port_t game_port;

	option_row_t rows [6];
	// Reference copies of both banks, 32 locations each
	logic [7:0] main_model [32];
	logic [7:0] aux_model  [32];
	logic [31:0] rng_state = 32'd94;
	int cycle_count = 0;

	tb_clock tb_clock_inst (
		.clk_sys  (clk_sys),
		.dd_reset (dd_reset)
	);

	a2_host_top a2_host_top_inst (
		.clk_sys (clk_sys), .dd_reset (dd_reset),
		.status (status), .forced_scandoubler (forced_scandoubler),
		.joystick_0 (joystick_0), .joystick_a0 (joystick_a0), .paddle_0 (paddle_0),
		.ram (ram), .ram_dout (ram_dout),
		.hdd_read (hdd_read), .hdd_write (hdd_write), .hdd_mounted (hdd_mounted),
		.hdd_protect (hdd_protect), .cpu_wait (cpu_wait),
		.sd_rd (sd_rd), .sd_wr (sd_wr), .sd_ack (sd_ack),
		.img_mounted (img_mounted), .img_size (img_size), .img_readonly (img_readonly),
		.core_audio_l (core_audio_l), .core_audio_r (core_audio_r),
		.audio_l (audio_l), .audio_r (audio_r), .audio_s (audio_s), .audio_mix (audio_mix),
		.video_cfg (video_cfg), .ce_pix (ce_pix), .game_port (game_port)
	);

	// ==================================================
	// Helpers
	// ==================================================
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic a2_host_pkg::a2_status_t make_status(input logic [2:0] display,
		input logic [2:0] fx, input logic [1:0] aspect, input logic swap,
		input logic px, input logic py);
		a2_host_pkg::a2_status_t s;
		s = '0;
		s.display     = display;
		s.fx          = fx;
		s.aspect      = aspect;
		s.analog_swap = swap;
		s.paddle_x    = px;
		s.paddle_y    = py;
		return s;
	endfunction

	function automatic a2_host_pkg::video_cfg_t make_video(input logic [1:0] mode,
		input logic text, input logic [1:0] scan, input logic hq, input logic sd,
		input logic [11:0] arx, input logic [11:0] ary);
		return '{mode, text, scan, hq, sd, arx, ary};
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			$display("mismatch %s expected %0h actual %0h", name, expected, actual);
			$display("RESULT: FAIL");
			$fatal(1, "value check failed");
		end
	endtask

	function automatic logic hdd_line(input int sel);
		case (sel)
			0:       return sd_rd;
			1:       return sd_wr;
			default: return cpu_wait;
		endcase
	endfunction

	// Waits up to three cycles for a handshake line to settle
	task automatic await_hdd(input int sel, input logic level, input string what);
		int n;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
		end while (hdd_line(sel) !== level && n < 3);
		if (hdd_line(sel) !== level) begin
			$display("%s did not reach %0b within 3 cycles", what, level);
			$display("RESULT: FAIL");
			$fatal(1, "hard-disk handshake stalled");
		end
	endtask

	task automatic pulse_request(input logic is_write);
		@(posedge clk_sys);
		if (is_write) hdd_write <= 1'b1;
		else hdd_read <= 1'b1;
		@(posedge clk_sys);
		hdd_write <= 1'b0;
		hdd_read  <= 1'b0;
	endtask

	// Host side of one transfer, optional write pulse while the CPU waits
	task automatic serve_request(input int sel, input string name, input logic queue_write);
		repeat (5) begin
			@(negedge clk_sys);
			check_value({name, " wait held"}, 64'(1), 64'(cpu_wait));
		end
		// Second request lands before the host answers
		if (queue_write) pulse_request(1'b1);
		@(posedge clk_sys);
		sd_ack <= 1'b1;
		await_hdd(sel, 1'b0, {name, " strobe"});
		check_value({name, " strobes after ack"}, 64'(0), 64'({sd_rd, sd_wr}));
		check_value({name, " wait after ack"}, 64'(1), 64'(cpu_wait));
		@(posedge clk_sys);
		sd_ack <= 1'b0;
		await_hdd(2, 1'b0, {name, " cpu_wait"});
	endtask

	task automatic mem_access(input logic we, input logic aux, input logic [4:0] idx,
		input logic [7:0] din, input logic check_other, input string name);
		logic [15:0] expected;
		@(posedge clk_sys);
		ram <= '{addr: {2'b10, 11'd0, idx}, din: din, we: we, aux: aux};
		@(posedge clk_sys);
		ram.we <= 1'b0;
		if (we && aux) aux_model[idx] = din;
		else if (we) main_model[idx] = din;
		expected = {aux_model[idx], main_model[idx]};
		@(negedge clk_sys);
		if (check_other) check_value(name, 64'(expected), 64'(ram_dout));
		else if (aux) check_value(name, 64'(expected[15:8]), 64'(ram_dout[15:8]));
		else check_value(name, 64'(expected[7:0]), 64'(ram_dout[7:0]));
	endtask

	// Audio word is a clear top bit, the sample, then five clear bits
	task automatic verify_audio(input logic [9:0] left, input logic [9:0] right,
		input logic [1:0] mix, input logic [15:0] left_word, input logic [15:0] right_word,
		input string name);
		@(posedge clk_sys);
		core_audio_l      <= left;
		core_audio_r      <= right;
		status.stereo_mix <= mix;
		@(negedge clk_sys);
		check_value({name, " audio_l"}, 64'(left_word), 64'(audio_l));
		check_value({name, " audio_r"}, 64'(right_word), 64'(audio_r));
		check_value({name, " audio_s"}, 64'(0), 64'(audio_s));
		check_value({name, " audio_mix"}, 64'(mix), 64'(audio_mix));
	endtask

	// First gap after the rate change is skipped
	task automatic check_pixel_rate(input logic normal, input int gap_expected,
		input string name);
		int gap;
		@(posedge clk_sys);
		status.pixel_normal <= normal;
		repeat (2) begin
			do @(negedge clk_sys); while (ce_pix !== 1'b1);
		end
		repeat (3) begin
			gap = 0;
			do begin
				@(negedge clk_sys);
				gap++;
			end while (ce_pix !== 1'b1);
			check_value(name, 64'(gap_expected), 64'(gap));
		end
	endtask

	task automatic mount_image(input logic [63:0] size, input logic ro,
		input logic [1:0] expected, input string name);
		@(posedge clk_sys);
		img_mounted  <= 1'b1;
		img_size     <= size;
		img_readonly <= ro;
		@(posedge clk_sys);
		img_mounted <= 1'b0;
		@(negedge clk_sys);
		check_value(name, 64'(expected), 64'({hdd_mounted, hdd_protect}));
	endtask

	// ==================================================
	// Timeout
	// ==================================================
	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the test sequence did not finish", cycle_count);
			$display("RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin
		status = '0;
		forced_scandoubler = 1'b0;
		joystick_0 = '0;
		joystick_a0 = '0;
		paddle_0 = '0;
		ram = '0;
		hdd_read = 1'b0;
		hdd_write = 1'b0;
		sd_ack = 1'b0;
		img_mounted = 1'b0;
		img_size = '0;
		img_readonly = 1'b0;
		core_audio_l = '0;
		core_audio_r = '0;

		// Status fields: display, fx, aspect, swap, paddle x, paddle y
		rows[0] = '{make_status(3'd0, 3'd0, 2'd0, 1'b0, 1'b0, 1'b0), 16'h003F, 16'h0000,
			8'h00, 1'b0, make_video(2'd0, 1'b0, 2'd0, 1'b0, 1'b0, 12'd4, 12'd3),
			{6'h3F, 16'h0000}};
		rows[1] = '{make_status(3'd1, 3'd1, 2'd1, 1'b0, 1'b0, 1'b0), 16'h003F, 16'h1200,
			8'h00, 1'b0, make_video(2'd0, 1'b1, 2'd0, 1'b1, 1'b1, 12'd0, 12'd0),
			{6'h33, 16'h0012}};
		rows[2] = '{make_status(3'd2, 3'd2, 2'd2, 1'b1, 1'b0, 1'b0), 16'h000F, 16'h3400,
			8'h00, 1'b0, make_video(2'd0, 1'b0, 2'd1, 1'b0, 1'b1, 12'd1, 12'd0),
			{6'h0C, 16'h3400}};
		rows[3] = '{make_status(3'd3, 3'd3, 2'd3, 1'b0, 1'b1, 1'b0), 16'h0033, 16'h0056,
			8'h80, 1'b0, make_video(2'd1, 1'b0, 2'd2, 1'b0, 1'b1, 12'd2, 12'd0),
			{6'h30, 16'h0000}};
		rows[4] = '{make_status(3'd4, 3'd4, 2'd0, 1'b1, 1'b0, 1'b1), 16'h003C, 16'h00F0,
			8'h10, 1'b0, make_video(2'd2, 1'b0, 2'd3, 1'b0, 1'b1, 12'd4, 12'd3),
			{6'h30, 16'h0090}};
		rows[5] = '{make_status(3'd5, 3'd0, 2'd1, 1'b0, 1'b1, 1'b1), 16'h0015, 16'h8001,
			8'h7F, 1'b1, make_video(2'd3, 1'b0, 2'd0, 1'b0, 1'b1, 12'd0, 12'd0),
			{6'h10, 16'hFFFF}};

		// Outputs cleared while reset is held
		@(negedge clk_sys);
		check_value("reset ce_pix", 64'(0), 64'(ce_pix));
		check_value("reset hdd lines", 64'(0),
			64'({sd_rd, sd_wr, cpu_wait, hdd_mounted, hdd_protect}));
		while (dd_reset) @(negedge clk_sys);

		for (int i = 0; i < 6; i++) begin
			@(posedge clk_sys);
			status             <= rows[i].status;
			joystick_0         <= rows[i].joy_dig_in;
			joystick_a0        <= rows[i].joy_an_in;
			paddle_0           <= rows[i].paddle;
			forced_scandoubler <= rows[i].forced;
			@(negedge clk_sys);
			check_value($sformatf("row %0d video_cfg", i), 64'(rows[i].video), 64'(video_cfg));
			check_value($sformatf("row %0d game_port", i), 64'(rows[i].port), 64'(game_port));
		end

		// Audio word placement and stereo mix pass-through
		verify_audio(10'h2A5, 10'h15A, 2'd2, 16'h54A0, 16'h2B40, "audio mid");
		verify_audio(10'h3FF, 10'h001, 2'd1, 16'h7FE0, 16'h0020, "audio edges");

		check_pixel_rate(1'b0, 4, "pixel gap double rate");
		check_pixel_rate(1'b1, 8, "pixel gap normal rate");

		// Fill both banks, then random writes each followed by a read
		for (int i = 0; i < 32; i++) begin
			rng_state = xorshift32(rng_state);
			mem_access(1'b1, 1'b0, 5'(i), rng_state[7:0], 1'b0, "main fill");
			mem_access(1'b1, 1'b1, 5'(i), rng_state[15:8], 1'b0, "aux fill");
		end
		repeat (40) begin
			rng_state = xorshift32(rng_state);
			mem_access(1'b1, rng_state[0], rng_state[5:1], rng_state[13:6], 1'b1,
				"write through");
			mem_access(1'b0, 1'b0, rng_state[5:1], 8'h00, 1'b1, "read back");
		end

		// Hard-disk read, write, then a write queued during a read
		pulse_request(1'b0);
		await_hdd(0, 1'b1, "sd_rd rise");
		check_value("read request lines", 64'(2'b10), 64'({cpu_wait, sd_wr}));
		serve_request(0, "read", 1'b0);
		pulse_request(1'b1);
		await_hdd(1, 1'b1, "sd_wr rise");
		check_value("write request lines", 64'(2'b10), 64'({cpu_wait, sd_rd}));
		serve_request(1, "write", 1'b0);
		pulse_request(1'b0);
		await_hdd(0, 1'b1, "sd_rd rise before queue");
		serve_request(0, "read with queued write", 1'b1);
		await_hdd(1, 1'b1, "queued sd_wr rise");
		check_value("queued write lines", 64'(2'b10), 64'({cpu_wait, sd_rd}));
		serve_request(1, "queued write", 1'b0);
		repeat (6) begin
			@(negedge clk_sys);
			check_value("no repeat request", 64'(0), 64'({sd_rd, sd_wr, cpu_wait}));
		end

		mount_image(64'h0000_0000_0010_0000, 1'b0, 2'b10, "mount writable");
		mount_image(64'd0, 1'b0, 2'b00, "eject");
		mount_image(64'h0000_0100_0000_0000, 1'b1, 2'b11, "mount read-only");

		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- compile.f
a2_host_pkg.sv
option_decode.sv
joystick_map.sv
bank_ram.sv
hdd_request.sv
a2_host_top.sv
tb_clock.sv
tb_a2_host.sv

//--- Makefile
# Verilator build and run of the host glue testbench

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module tb_a2_host -Mdir obj_dir -f compile.f
	./obj_dir/Vtb_a2_host | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
